/* run_sim.sh */
#!/usr/bin/env bash
# build and run the reflex network testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module reflex_tb \
    -Mdir obj_dir -f src.f \
    && ./obj_dir/Vreflex_tb +verilator+error+limit+1000 > sim.log 2>&1

cat sim.log 2>/dev/null

grep -qx "NO ERRORS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* src.f */
verilog/neuro_fmt_pkg.sv
verilog/host_map_pkg.sv
verilog/reflex_param_if.sv
verilog/param_bank.sv
verilog/synapse.sv
verilog/spiking_neuron.sv
verilog/drive_mixer.sv
verilog/motor_pool.sv
verilog/reflex_top.sv
verif/reflex_assert.sv
verif/reflex_tb.sv

/* verif/reflex_assert.sv */
module reflex_assert (
    input  logic                              i_ep50trig,
    input  logic                              i_reset_sim,
    input  logic                              i_trig_valid,
    input  logic [host_map_pkg::trig_w-1:0]   i_trig_idx,
    input  neuro_fmt_pkg::current_t           i_trig_data,
    input  logic [host_map_pkg::rd_idx_w-1:0] i_rd_idx,
    input  logic                              i_ia_spike,
    input  logic                              i_ii_spike,
    input  neuro_fmt_pkg::current_t           o_rd_data,
    input  logic                              o_cn_spike,
    input  logic                              o_cn2_spike,
    input  logic [2:0]                        o_mn_spike,
    input  neuro_fmt_pkg::count_t             o_count_mn1,
    input  neuro_fmt_pkg::count_t             o_count_mn3,
    input  neuro_fmt_pkg::count_t             o_count_mn5,
    input  neuro_fmt_pkg::count_t             o_total_count
);

    import neuro_fmt_pkg::*;
    import host_map_pkg::*;

    // failures per rule
    int unsigned err_rd = 0;
    int unsigned err_quiet = 0;
    int unsigned err_cnt1 = 0;
    int unsigned err_cnt3 = 0;
    int unsigned err_cnt5 = 0;
    int unsigned err_order = 0;
    int unsigned err_total = 0;
    int unsigned fail_total;

    // host registers seen from the bus by trigger index
    current_t ref_q [2**trig_w];
    current_t exp_rd_q;
    logic     exp_vld_q;

    // sticky flag set by any drive or sensory spike since reset
    logic stim_q;

    // expected spike counts
    count_t ref_cnt1_q;
    count_t ref_cnt3_q;
    count_t ref_cnt5_q;
    count_t exp_total;

    function automatic logic is_mapped(input logic [trig_w-1:0] idx);
        return idx == trig_gain_sn_mn || idx == trig_gain_cn_mn || idx == trig_gain_cn2_mn
            || idx == trig_gain_sn_cn || idx == trig_drive_cn || idx == trig_drive_cn2;
    endfunction

    // one term of the weighted total
    function automatic count_t weighted_share(input count_t cnt, input int w);
        count_t prod;
        prod = cnt * count_t'(w);
        return prod >> weight_shift;
    endfunction

    //////////////////////////////
    // reference model
    //////////////////////////////
    always_ff @(posedge i_ep50trig or posedge i_reset_sim)
    begin
        if (i_reset_sim)
        begin
            for (int i = 0; i < 2**trig_w; i++)
            begin
                ref_q[i] <= '0;
            end
            ref_q[trig_gain_sn_mn]  <= rst_gain_sn_mn;
            ref_q[trig_gain_sn_cn]  <= rst_gain_sn_cn;
            ref_q[trig_gain_cn_mn]  <= rst_gain_cn_mn;
            ref_q[trig_gain_cn2_mn] <= rst_gain_cn2_mn;
            ref_q[trig_drive_cn]    <= rst_drive_cn;
            ref_q[trig_drive_cn2]   <= rst_drive_cn2;
            exp_rd_q   <= '0;
            exp_vld_q  <= 1'b0;
            stim_q     <= 1'b0;
            ref_cnt1_q <= '0;
            ref_cnt3_q <= '0;
            ref_cnt5_q <= '0;
        end
        else
        begin
            // unknown index leaves every register alone
            if (i_trig_valid && is_mapped(i_trig_idx))
            begin
                ref_q[i_trig_idx] <= i_trig_data;
            end
            exp_rd_q  <= ref_q[i_rd_idx];
            exp_vld_q <= is_mapped(i_rd_idx);
            stim_q    <= stim_q || i_ia_spike || i_ii_spike
                      || ref_q[trig_drive_cn] != 0 || ref_q[trig_drive_cn2] != 0;
            // one more count per spike one edge later
            ref_cnt1_q <= ref_cnt1_q + count_t'(o_mn_spike[0]);
            ref_cnt3_q <= ref_cnt3_q + count_t'(o_mn_spike[1]);
            ref_cnt5_q <= ref_cnt5_q + count_t'(o_mn_spike[2]);
        end
    end

    // crossed weights 13 30 75 on the expected counts
    assign exp_total = weighted_share(ref_cnt1_q, cnt_w_mn1)
                     + weighted_share(ref_cnt3_q, cnt_w_mn3)
                     + weighted_share(ref_cnt5_q, cnt_w_mn5);

    assign fail_total = err_rd + err_quiet + err_cnt1 + err_cnt3 + err_cnt5
                      + err_order + err_total;

    //////////////////////////////
    // checks
    //////////////////////////////
    a_readback: assert property (@(posedge i_ep50trig) disable iff (i_reset_sim)
        exp_vld_q |-> o_rd_data == exp_rd_q)
    else
    begin
        $error("Mismatch at %0t: o_rd_data is %0h, expected %0h",
            $time, $sampled(o_rd_data), $sampled(exp_rd_q));
        err_rd++;
    end

    // no input means no activity anywhere
    a_quiet: assert property (@(posedge i_ep50trig) disable iff (i_reset_sim)
        !stim_q |-> (!o_cn_spike && !o_cn2_spike && o_mn_spike == 3'b000
            && o_count_mn1 == '0 && o_count_mn3 == '0 && o_count_mn5 == '0))
    else
    begin
        $error("network active at %0t with no drive and no sensory spike since reset", $time);
        err_quiet++;
    end

    a_count_mn1: assert property (@(posedge i_ep50trig) disable iff (i_reset_sim)
        o_count_mn1 == ref_cnt1_q)
    else
    begin
        $error("Mismatch at %0t: o_count_mn1 is %0d, expected %0d",
            $time, $sampled(o_count_mn1), $sampled(ref_cnt1_q));
        err_cnt1++;
    end

    a_count_mn3: assert property (@(posedge i_ep50trig) disable iff (i_reset_sim)
        o_count_mn3 == ref_cnt3_q)
    else
    begin
        $error("Mismatch at %0t: o_count_mn3 is %0d, expected %0d",
            $time, $sampled(o_count_mn3), $sampled(ref_cnt3_q));
        err_cnt3++;
    end

    a_count_mn5: assert property (@(posedge i_ep50trig) disable iff (i_reset_sim)
        o_count_mn5 == ref_cnt5_q)
    else
    begin
        $error("Mismatch at %0t: o_count_mn5 is %0d, expected %0d",
            $time, $sampled(o_count_mn5), $sampled(ref_cnt5_q));
        err_cnt5++;
    end

    // size principle keeps small cells ahead
    a_size_order: assert property (@(posedge i_ep50trig) disable iff (i_reset_sim)
        o_count_mn1 >= o_count_mn3 && o_count_mn3 >= o_count_mn5)
    else
    begin
        $error("size order broken at %0t: counts mn1 %0d, mn3 %0d, mn5 %0d", $time,
            $sampled(o_count_mn1), $sampled(o_count_mn3), $sampled(o_count_mn5));
        err_order++;
    end

    a_total: assert property (@(posedge i_ep50trig) disable iff (i_reset_sim)
        o_total_count == exp_total)
    else
    begin
        $error("Mismatch at %0t: o_total_count is %0d, expected %0d",
            $time, $sampled(o_total_count), $sampled(exp_total));
        err_total++;
    end

endmodule

/* verif/reflex_tb.sv */
module tb_clock #(
    parameter int half_period  = 2,
    parameter int reset_cycles = 8
) (
    output logic o_ep50trig,
    output logic o_reset_sim
);

    initial
    begin
        o_ep50trig = 1'b0;
        forever #half_period o_ep50trig = ~o_ep50trig;
    end

    // released on a rising edge, like every other input
    initial
    begin
        o_reset_sim = 1'b1;
        repeat (reset_cycles) @(posedge o_ep50trig);
        o_reset_sim <= 1'b0;
    end

endmodule

module reflex_tb;

    import neuro_fmt_pkg::*;
    import host_map_pkg::*;

    //////////////////////////////
    // run length
    //////////////////////////////
    localparam int quiet_len   = 200;
    localparam int write_len   = 60;
    localparam int cortex_len  = 400;
    localparam int random_len  = 800;
    localparam int cycle_limit = 2 * (quiet_len + write_len + cortex_len + random_len);

    logic                ep50trig;
    logic                reset_sim;
    logic                trig_valid;
    logic [trig_w-1:0]   trig_idx;
    current_t            trig_data;
    logic [rd_idx_w-1:0] rd_idx;
    logic                ia_spike;
    logic                ii_spike;
    current_t            rd_data;
    logic                cn_spike;
    logic                cn2_spike;
    logic [2:0]          mn_spike;
    count_t              count_mn1;
    count_t              count_mn3;
    count_t              count_mn5;
    count_t              total_count;

    // lcg state, fixed seed
    logic [31:0] lcg_state = 32'd85;

    int unsigned cycle_cnt   = 0;
    int unsigned timeout_cnt = 0;
    int unsigned miss_cnt    = 0;
    logic        cn_seen     = 1'b0;
    logic        mn_seen     = 1'b0;

    tb_clock clk_i (
        .o_ep50trig  (ep50trig),
        .o_reset_sim (reset_sim)
    );

    reflex_top dut_i (
        .i_ep50trig    (ep50trig),
        .i_reset_sim   (reset_sim),
        .i_trig_valid  (trig_valid),
        .i_trig_idx    (trig_idx),
        .i_trig_data   (trig_data),
        .i_rd_idx      (rd_idx),
        .i_ia_spike    (ia_spike),
        .i_ii_spike    (ii_spike),
        .o_rd_data     (rd_data),
        .o_cn_spike    (cn_spike),
        .o_cn2_spike   (cn2_spike),
        .o_mn_spike    (mn_spike),
        .o_count_mn1   (count_mn1),
        .o_count_mn3   (count_mn3),
        .o_count_mn5   (count_mn5),
        .o_total_count (total_count)
    );

    // network rules checked inside the top level
    bind reflex_top reflex_assert assert_i (
        .i_ep50trig    (i_ep50trig),
        .i_reset_sim   (i_reset_sim),
        .i_trig_valid  (i_trig_valid),
        .i_trig_idx    (i_trig_idx),
        .i_trig_data   (i_trig_data),
        .i_rd_idx      (i_rd_idx),
        .i_ia_spike    (i_ia_spike),
        .i_ii_spike    (i_ii_spike),
        .o_rd_data     (o_rd_data),
        .o_cn_spike    (o_cn_spike),
        .o_cn2_spike   (o_cn2_spike),
        .o_mn_spike    (o_mn_spike),
        .o_count_mn1   (o_count_mn1),
        .o_count_mn3   (o_count_mn3),
        .o_count_mn5   (o_count_mn5),
        .o_total_count (o_total_count)
    );

    //////////////////////////////
    // helpers
    //////////////////////////////
    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic write_param(input logic [trig_w-1:0] idx, input current_t data);
        @(posedge ep50trig);
        trig_valid <= 1'b1;
        trig_idx   <= idx;
        trig_data  <= data;
        @(posedge ep50trig);
        trig_valid <= 1'b0;
    endtask

    // data shows one edge later, checked by the bound module
    task automatic select_readback(input logic [rd_idx_w-1:0] idx);
        @(posedge ep50trig);
        rd_idx <= idx;
    endtask

    task automatic close_run;
        int unsigned total;
        total = dut_i.assert_i.fail_total + timeout_cnt + miss_cnt;
        $display("assertion failures %0d, timeouts %0d, stimulus misses %0d",
            dut_i.assert_i.fail_total, timeout_cnt, miss_cnt);
        if (total == 0)
        begin
            $display("NO ERRORS");
        end
        else
        begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    // watchdog
    always @(posedge ep50trig)
    begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit)
        begin
            timeout_cnt++;
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            close_run();
        end
    end

    // spikes sampled away from the driving edge
    always @(negedge ep50trig)
    begin
        if (cn_spike)
        begin
            cn_seen = 1'b1;
        end
        if (mn_spike != 3'b000)
        begin
            mn_seen = 1'b1;
        end
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////
    initial
    begin
        count_t goal;
        int     waited;
        trig_valid = 1'b0;
        trig_idx   = '0;
        trig_data  = '0;
        rd_idx     = '0;
        ia_spike   = 1'b0;
        ii_spike   = 1'b0;
        @(negedge reset_sim);

        // reset values, network at rest
        for (int k = 0; k < n_params; k++)
        begin
            select_readback(slot_trig[k]);
        end
        repeat (quiet_len) @(posedge ep50trig);

        // write then read back, positive data only
        for (int k = 0; k < n_params; k++)
        begin
            lcg_state = lcg_step(lcg_state);
            write_param(slot_trig[k], lcg_state & 32'h0000_ffff);
            select_readback(slot_trig[k]);
        end
        // unmapped indices 0 and 15
        lcg_state = lcg_step(lcg_state);
        write_param(4'd0, lcg_state);
        lcg_state = lcg_step(lcg_state);
        write_param(4'd15, lcg_state);
        for (int k = 0; k < n_params; k++)
        begin
            select_readback(slot_trig[k]);
        end

        // strong cortical drive into the pool
        write_param(trig_drive_cn, 40000);
        write_param(trig_gain_cn_mn, 8);
        @(negedge ep50trig);
        goal   = count_mn5 + 5;
        waited = 0;
        while (count_mn5 < goal && waited < cortex_len)
        begin
            @(negedge ep50trig);
            waited++;
        end
        if (count_mn5 < goal)
        begin
            miss_cnt++;
            $display("largest motor neuron never fired under cortical drive");
        end

        // random Ia and II trains, drives off
        write_param(trig_drive_cn, 0);
        write_param(trig_drive_cn2, 0);
        write_param(trig_gain_sn_mn, 4);
        write_param(trig_gain_sn_cn, 2);
        repeat (random_len)
        begin
            lcg_state = lcg_step(lcg_state);
            @(posedge ep50trig);
            ia_spike <= (lcg_state[31:29] == 3'd0);
            ii_spike <= (lcg_state[28:26] == 3'd0);
        end
        @(posedge ep50trig);
        ia_spike <= 1'b0;
        ii_spike <= 1'b0;
        repeat (10) @(posedge ep50trig);

        if (!cn_seen)
        begin
            miss_cnt++;
            $display("cortical neuron never fired during the run");
        end
        if (!mn_seen)
        begin
            miss_cnt++;
            $display("no motor neuron fired during the run");
        end
        close_run();
    end

endmodule

/* verilog/drive_mixer.sv */
module drive_mixer (
    input  logic                    i_ep50trig,
    input  logic                    i_reset_sim,
    input  neuro_fmt_pkg::current_t i_epsc_ia_mn,
    input  neuro_fmt_pkg::current_t i_epsc_ii_mn,
    input  neuro_fmt_pkg::current_t i_epsc_cn_mn,
    input  neuro_fmt_pkg::current_t i_epsc_cn2_mn,
    input  neuro_fmt_pkg::current_t i_epsc_sn_cn,
    input  neuro_fmt_pkg::current_t i_epsc_sn_cn2,
    reflex_param_if.sink            prm,
    output neuro_fmt_pkg::current_t o_drive_cn,
    output neuro_fmt_pkg::current_t o_drive_cn2,
    output neuro_fmt_pkg::current_t o_drive_mn
);

    import neuro_fmt_pkg::*;

    // unlatched sums
    current_t sum_cn;
    current_t sum_cn2;
    current_t sum_mn;

    // cortical: sensory psc plus voluntary drive
    assign sum_cn  = i_epsc_sn_cn + prm.drive_cn;
    assign sum_cn2 = i_epsc_sn_cn2 + prm.drive_cn2;

    // spinal and transcortical paths add at the motor pool
    assign sum_mn = i_epsc_ia_mn + i_epsc_ii_mn + i_epsc_cn_mn + i_epsc_cn2_mn;

    //////////////////////////////
    // drive latch
    //////////////////////////////
    always_ff @(posedge i_ep50trig or posedge i_reset_sim)
    begin
        if (i_reset_sim)
        begin
            o_drive_cn  <= '0;
            o_drive_cn2 <= '0;
            o_drive_mn  <= '0;
        end
        else
        begin
            o_drive_cn  <= sum_cn;
            o_drive_cn2 <= sum_cn2;
            o_drive_mn  <= sum_mn;
        end
    end

endmodule

/* verilog/host_map_pkg.sv */
package host_map_pkg;

    // trigger index width
    localparam int trig_w = 4;

    // readback select uses the trigger numbering
    localparam int rd_idx_w = trig_w;

    //////////////////////////////
    // trigger indices
    //////////////////////////////
    localparam logic [trig_w-1:0] trig_gain_cn_mn  = 4'd3;
    localparam logic [trig_w-1:0] trig_gain_sn_mn  = 4'd6;
    localparam logic [trig_w-1:0] trig_gain_cn2_mn = 4'd9;
    localparam logic [trig_w-1:0] trig_drive_cn    = 4'd10;
    localparam logic [trig_w-1:0] trig_drive_cn2   = 4'd11;
    localparam logic [trig_w-1:0] trig_gain_sn_cn  = 4'd12;

    // readable parameters held by the bank
    localparam int n_params = 6;

    // slot of each parameter inside the bank
    localparam int slot_gain_sn_mn  = 0;
    localparam int slot_gain_sn_cn  = 1;
    localparam int slot_gain_cn_mn  = 2;
    localparam int slot_gain_cn2_mn = 3;
    localparam int slot_drive_cn    = 4;
    localparam int slot_drive_cn2   = 5;

    //////////////////////////////
    // reset values
    //////////////////////////////
    // gains come up at 1, voluntary drives at rest
    localparam neuro_fmt_pkg::current_t rst_gain_sn_mn  = 1;
    localparam neuro_fmt_pkg::current_t rst_gain_sn_cn  = 1;
    localparam neuro_fmt_pkg::current_t rst_gain_cn_mn  = 1;
    localparam neuro_fmt_pkg::current_t rst_gain_cn2_mn = 1;
    localparam neuro_fmt_pkg::current_t rst_drive_cn    = 0;
    localparam neuro_fmt_pkg::current_t rst_drive_cn2   = 0;

    // per-slot tables, slot 0 in the low bits
    localparam logic [n_params-1:0][trig_w-1:0] slot_trig = {
        trig_drive_cn2, trig_drive_cn, trig_gain_cn2_mn,
        trig_gain_cn_mn, trig_gain_sn_cn, trig_gain_sn_mn
    };
    localparam logic [n_params-1:0][neuro_fmt_pkg::word_w-1:0] slot_rst = {
        rst_drive_cn2, rst_drive_cn, rst_gain_cn2_mn,
        rst_gain_cn_mn, rst_gain_sn_cn, rst_gain_sn_mn
    };

endpackage

/* verilog/motor_pool.sv */
module motor_pool (
    input  logic                    i_ep50trig,
    input  logic                    i_reset_sim,
    input  neuro_fmt_pkg::current_t i_drive_mn,
    output logic [2:0]              o_mn_spike,
    output neuro_fmt_pkg::count_t   o_count_mn1,
    output neuro_fmt_pkg::count_t   o_count_mn3,
    output neuro_fmt_pkg::count_t   o_count_mn5,
    output neuro_fmt_pkg::count_t   o_total_count
);

    import neuro_fmt_pkg::*;

    // bit 0 mn1, bit 1 mn3, bit 2 mn5
    logic [2:0] mn_spike;

    // spike counters, same bit order
    count_t count_q [3];

    //////////////////////////////
    // size-principle pool
    //////////////////////////////
    // same drive, heavier weight recruits first
    spiking_neuron #(.weight(w_mn1)) mn1_i (
        .i_ep50trig  (i_ep50trig),
        .i_reset_sim (i_reset_sim),
        .i_drive     (i_drive_mn),
        .o_spike     (mn_spike[0])
    );

    spiking_neuron #(.weight(w_mn3)) mn3_i (
        .i_ep50trig  (i_ep50trig),
        .i_reset_sim (i_reset_sim),
        .i_drive     (i_drive_mn),
        .o_spike     (mn_spike[1])
    );

    spiking_neuron #(.weight(w_mn5)) mn5_i (
        .i_ep50trig  (i_ep50trig),
        .i_reset_sim (i_reset_sim),
        .i_drive     (i_drive_mn),
        .o_spike     (mn_spike[2])
    );

    //////////////////////////////
    // spike counters
    //////////////////////////////
    // registered, count shows a spike one edge later
    always_ff @(posedge i_ep50trig or posedge i_reset_sim)
    begin
        if (i_reset_sim)
        begin
            for (int k = 0; k < 3; k++)
            begin
                count_q[k] <= '0;
            end
        end
        else
        begin
            for (int k = 0; k < 3; k++)
            begin
                if (mn_spike[k])
                begin
                    count_q[k] <= count_q[k] + 1'b1;
                end
            end
        end
    end

    assign o_mn_spike  = mn_spike;
    assign o_count_mn1 = count_q[0];
    assign o_count_mn3 = count_q[1];
    assign o_count_mn5 = count_q[2];

    // weighted total, crossed weights, one-word wrap
    assign o_total_count = ((count_q[0] * cnt_w_mn1) >> weight_shift)
                         + ((count_q[1] * cnt_w_mn3) >> weight_shift)
                         + ((count_q[2] * cnt_w_mn5) >> weight_shift);

endmodule

/* verilog/neuro_fmt_pkg.sv */
package neuro_fmt_pkg;

    //////////////////////////////
    // number format
    //////////////////////////////

    // one word for currents, potentials and parameters
    localparam int word_w = 32;

    // signed current, fixed point scaled by 1024
    typedef logic signed [word_w-1:0] current_t;

    // free-running spike count
    typedef logic [word_w-1:0] count_t;

    //////////////////////////////
    // synapse and neuron constants
    //////////////////////////////

    // psc value right after a presynaptic spike
    localparam current_t epsc_peak = 1024;

    // per-cycle decay, current minus current >> 3
    localparam int epsc_decay_shift = 3;

    // 30 mV, scaled x1024
    localparam current_t v_threshold = 30720;

    // input weights are in 1/16 steps
    localparam int weight_shift = 4;

    // unity weight, used by the cortical neurons
    localparam int w_unity = 16;

    // motor neuron input weights, smallest cell gets the largest weight
    localparam int w_mn1 = 75;
    localparam int w_mn3 = 30;
    localparam int w_mn5 = 13;

    // weights for the total count, crossed order against the inputs
    localparam int cnt_w_mn1 = 13;
    localparam int cnt_w_mn3 = 30;
    localparam int cnt_w_mn5 = 75;

endpackage

/* verilog/param_bank.sv */
module param_bank (
    input  logic                               i_ep50trig,
    input  logic                               i_reset_sim,
    input  logic                               i_trig_valid,
    input  logic [host_map_pkg::trig_w-1:0]    i_trig_idx,
    input  neuro_fmt_pkg::current_t            i_trig_data,
    input  logic [host_map_pkg::rd_idx_w-1:0]  i_rd_idx,
    output neuro_fmt_pkg::current_t            o_rd_data,
    reflex_param_if.source                     prm
);

    import neuro_fmt_pkg::*;
    import host_map_pkg::*;

    // one register per readable parameter
    current_t prm_q [n_params];

    // readback mux output, before the register
    current_t rd_sel;

    //////////////////////////////
    // trigger-strobe load
    //////////////////////////////
    // one write per strobe, unknown index matches no slot
    always_ff @(posedge i_ep50trig or posedge i_reset_sim)
    begin
        if (i_reset_sim)
        begin
            for (int s = 0; s < n_params; s++)
            begin
                prm_q[s] <= slot_rst[s];
            end
        end
        else if (i_trig_valid)
        begin
            for (int s = 0; s < n_params; s++)
            begin
                if (i_trig_idx == slot_trig[s])
                begin
                    prm_q[s] <= i_trig_data;
                end
            end
        end
    end

    // out to the network
    assign prm.gain_sn_mn  = prm_q[slot_gain_sn_mn];
    assign prm.gain_sn_cn  = prm_q[slot_gain_sn_cn];
    assign prm.gain_cn_mn  = prm_q[slot_gain_cn_mn];
    assign prm.gain_cn2_mn = prm_q[slot_gain_cn2_mn];
    assign prm.drive_cn    = prm_q[slot_drive_cn];
    assign prm.drive_cn2   = prm_q[slot_drive_cn2];

    //////////////////////////////
    // readback
    //////////////////////////////
    // select by trigger index, zero when nothing matches
    always_comb
    begin
        rd_sel = '0;
        for (int s = 0; s < n_params; s++)
        begin
            if (i_rd_idx == slot_trig[s])
            begin
                rd_sel = prm_q[s];
            end
        end
    end

    // one cycle from select to data
    always_ff @(posedge i_ep50trig or posedge i_reset_sim)
    begin
        if (i_reset_sim)
        begin
            o_rd_data <= '0;
        end
        else
        begin
            o_rd_data <= rd_sel;
        end
    end

endmodule

/* verilog/reflex_param_if.sv */
interface reflex_param_if;

    import neuro_fmt_pkg::*;

    // synapse gains, plain integers
    current_t gain_sn_mn;
    current_t gain_sn_cn;
    current_t gain_cn_mn;
    current_t gain_cn2_mn;

    // voluntary drive into the cortical neurons
    current_t drive_cn;
    current_t drive_cn2;

    // parameter bank side
    modport source (
        output gain_sn_mn,
        output gain_sn_cn,
        output gain_cn_mn,
        output gain_cn2_mn,
        output drive_cn,
        output drive_cn2
    );

    // network side
    modport sink (
        input gain_sn_mn,
        input gain_sn_cn,
        input gain_cn_mn,
        input gain_cn2_mn,
        input drive_cn,
        input drive_cn2
    );

endinterface

/* verilog/reflex_top.sv */
module reflex_top (
    input  logic                               i_ep50trig,
    input  logic                               i_reset_sim,
    input  logic                               i_trig_valid,
    input  logic [host_map_pkg::trig_w-1:0]    i_trig_idx,
    input  neuro_fmt_pkg::current_t            i_trig_data,
    input  logic [host_map_pkg::rd_idx_w-1:0]  i_rd_idx,
    input  logic                               i_ia_spike,
    input  logic                               i_ii_spike,
    output neuro_fmt_pkg::current_t            o_rd_data,
    output logic                               o_cn_spike,
    output logic                               o_cn2_spike,
    output logic [2:0]                         o_mn_spike,
    output neuro_fmt_pkg::count_t              o_count_mn1,
    output neuro_fmt_pkg::count_t              o_count_mn3,
    output neuro_fmt_pkg::count_t              o_count_mn5,
    output neuro_fmt_pkg::count_t              o_total_count
);

    import neuro_fmt_pkg::*;

    // gains and drives from the bank
    reflex_param_if prm ();

    // gained synaptic currents
    current_t epsc_ia_mn;
    current_t epsc_ii_mn;
    current_t epsc_sn_cn;
    current_t epsc_sn_cn2;
    current_t epsc_cn_mn;
    current_t epsc_cn2_mn;

    // latched drives
    current_t drive_cn;
    current_t drive_cn2;
    current_t drive_mn;

    //////////////////////////////
    // host parameters
    //////////////////////////////
    param_bank bank_i (
        .i_ep50trig   (i_ep50trig),
        .i_reset_sim  (i_reset_sim),
        .i_trig_valid (i_trig_valid),
        .i_trig_idx   (i_trig_idx),
        .i_trig_data  (i_trig_data),
        .i_rd_idx     (i_rd_idx),
        .o_rd_data    (o_rd_data),
        .prm          (prm)
    );

    //////////////////////////////
    // synapses
    //////////////////////////////
    // short-latency spinal path, Ia and II share one gain
    synapse ia_mn (.i_ep50trig(i_ep50trig), .i_reset_sim(i_reset_sim),
        .i_spike(i_ia_spike), .i_gain(prm.gain_sn_mn), .o_epsc(epsc_ia_mn));
    synapse ii_mn (.i_ep50trig(i_ep50trig), .i_reset_sim(i_reset_sim),
        .i_spike(i_ii_spike), .i_gain(prm.gain_sn_mn), .o_epsc(epsc_ii_mn));

    // Ia to both cortical neurons, one shared gain
    synapse sn_cn (.i_ep50trig(i_ep50trig), .i_reset_sim(i_reset_sim),
        .i_spike(i_ia_spike), .i_gain(prm.gain_sn_cn), .o_epsc(epsc_sn_cn));
    synapse sn_cn2 (.i_ep50trig(i_ep50trig), .i_reset_sim(i_reset_sim),
        .i_spike(i_ia_spike), .i_gain(prm.gain_sn_cn), .o_epsc(epsc_sn_cn2));

    // long-latency transcortical path
    synapse cn_mn (.i_ep50trig(i_ep50trig), .i_reset_sim(i_reset_sim),
        .i_spike(o_cn_spike), .i_gain(prm.gain_cn_mn), .o_epsc(epsc_cn_mn));
    synapse cn2_mn (.i_ep50trig(i_ep50trig), .i_reset_sim(i_reset_sim),
        .i_spike(o_cn2_spike), .i_gain(prm.gain_cn2_mn), .o_epsc(epsc_cn2_mn));

    //////////////////////////////
    // drives and neurons
    //////////////////////////////
    drive_mixer mixer_i (
        .i_ep50trig    (i_ep50trig),
        .i_reset_sim   (i_reset_sim),
        .i_epsc_ia_mn  (epsc_ia_mn),
        .i_epsc_ii_mn  (epsc_ii_mn),
        .i_epsc_cn_mn  (epsc_cn_mn),
        .i_epsc_cn2_mn (epsc_cn2_mn),
        .i_epsc_sn_cn  (epsc_sn_cn),
        .i_epsc_sn_cn2 (epsc_sn_cn2),
        .prm           (prm),
        .o_drive_cn    (drive_cn),
        .o_drive_cn2   (drive_cn2),
        .o_drive_mn    (drive_mn)
    );

    // cortical neurons at unity weight
    spiking_neuron cn_i (.i_ep50trig(i_ep50trig), .i_reset_sim(i_reset_sim),
        .i_drive(drive_cn), .o_spike(o_cn_spike));
    spiking_neuron cn2_i (.i_ep50trig(i_ep50trig), .i_reset_sim(i_reset_sim),
        .i_drive(drive_cn2), .o_spike(o_cn2_spike));

    motor_pool pool_i (
        .i_ep50trig    (i_ep50trig),
        .i_reset_sim   (i_reset_sim),
        .i_drive_mn    (drive_mn),
        .o_mn_spike    (o_mn_spike),
        .o_count_mn1   (o_count_mn1),
        .o_count_mn3   (o_count_mn3),
        .o_count_mn5   (o_count_mn5),
        .o_total_count (o_total_count)
    );

endmodule

/* verilog/spiking_neuron.sv */
module spiking_neuron #(
    parameter int weight = neuro_fmt_pkg::w_unity
) (
    input  logic                    i_ep50trig,
    input  logic                    i_reset_sim,
    input  neuro_fmt_pkg::current_t i_drive,
    output logic                    o_spike
);

    import neuro_fmt_pkg::*;

    // membrane potential, x1024
    current_t v_q;

    // weighted input and next potential, wide to avoid overflow
    logic signed [2*word_w-1:0] drive_w;
    logic signed [2*word_w-1:0] v_sum;

    // input scaled by weight/16
    assign drive_w = (i_drive * weight) >>> weight_shift;

    // integrate
    assign v_sum = v_q + drive_w;

    //////////////////////////////
    // integrate and fire
    //////////////////////////////
    always_ff @(posedge i_ep50trig or posedge i_reset_sim)
    begin
        if (i_reset_sim)
        begin
            v_q     <= '0;
            o_spike <= 1'b0;
        end
        else if (v_sum >= v_threshold)
        begin
            // fire, back to rest
            v_q     <= '0;
            o_spike <= 1'b1;
        end
        else if (v_sum < 0)
        begin
            // floor at rest
            v_q     <= '0;
            o_spike <= 1'b0;
        end
        else
        begin
            // below threshold, fits one word
            v_q     <= v_sum[word_w-1:0];
            o_spike <= 1'b0;
        end
    end

endmodule

/* verilog/synapse.sv */
module synapse (
    input  logic                    i_ep50trig,
    input  logic                    i_reset_sim,
    input  logic                    i_spike,
    input  neuro_fmt_pkg::current_t i_gain,
    output neuro_fmt_pkg::current_t o_epsc
);

    import neuro_fmt_pkg::*;

    // pre-gain postsynaptic current
    current_t psc_q;

    // full product, only the low word leaves
    logic signed [2*word_w-1:0] psc_gain;

    //////////////////////////////
    // psc state
    //////////////////////////////
    // spike sets the peak, otherwise exponential-ish decay
    // small values stall below 8, stays non-negative
    always_ff @(posedge i_ep50trig or posedge i_reset_sim)
    begin
        if (i_reset_sim)
        begin
            psc_q <= '0;
        end
        else if (i_spike)
        begin
            psc_q <= epsc_peak;
        end
        else
        begin
            psc_q <= psc_q - (psc_q >>> epsc_decay_shift);
        end
    end

    //////////////////////////////
    // gain stage
    //////////////////////////////
    // combinational, host gain is a plain integer
    assign psc_gain = psc_q * i_gain;

    // low word, wraps like the 32-bit multiplier
    assign o_epsc = psc_gain[word_w-1:0];

endmodule
